// File: verilog/fe_pkg.sv
// shared widths, reset pc, branch bus and opcode class for the fetch front end
package fe_pkg;

  // datapath widths
  localparam int INST_WD      = 32;
  localparam int PC_WD        = 32;
  localparam int SRAM_DATA_WD = 64;
  localparam int SRAM_ADDR_WD = 29; // pc[31:3], one 64-bit word per address

  // first fetched address
  localparam logic [PC_WD-1:0] PC_RESETVAL = 32'h8000_0000;

  // sequential step of the fetch pc
  localparam logic [PC_WD-1:0] PC_STEP = 32'd4;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_JAL   = 7'b1101111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_ALU   = 7'b0110011; // register-register
  localparam logic [6:0] OPC_ALUI  = 7'b0010011; // register-immediate

  // jump from decode back to the pc generator
  typedef struct packed {
    logic             br_sel;    // one-cycle jump pulse
    logic [PC_WD-1:0] br_target;
  } br_bus_t;

  // instruction class seen by the execute stage
  typedef enum logic [2:0] {
    OP_JAL,
    OP_LOAD,
    OP_STORE,
    OP_ALU,
    OP_OTHER
  } op_e;

endpackage

// File: verilog/fetch_if.sv
// fetch to decode link, valid/allowin strobes with instruction and pc
`timescale 1ns/10ps

interface fetch_if;

  logic                      valid;   // fetch holds an item
  logic                      allowin; // decode can take it this cycle
  logic [fe_pkg::INST_WD-1:0] inst;
  logic [fe_pkg::PC_WD-1:0]   pc;

  // fetch side
  modport producer (
    output valid,
    output inst,
    output pc,
    input  allowin
  );

  // decode side
  modport consumer (
    input  valid,
    input  inst,
    input  pc,
    output allowin
  );

endinterface

// File: verilog/fe_pc_gen.sv
// fetch pc register with redirect handling, issues the instruction sram read
`timescale 1ns/10ps

module fe_pc_gen (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_load,   // fetch stage takes a new item
  input  fe_pkg::br_bus_t                i_br_bus,
  output logic [fe_pkg::PC_WD-1:0]        o_pc,
  output logic                           o_inst_sram_ren,
  output logic [fe_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic [fe_pkg::PC_WD-1:0] pc_q;
  logic                     pend_q;        // jump seen while fetch was stalled
  logic [fe_pkg::PC_WD-1:0] pend_target_q;
  logic                     redirect;
  logic [fe_pkg::PC_WD-1:0] redirect_target;
  logic [fe_pkg::PC_WD-1:0] nxt_pc;

  // a fresh pulse wins over an older pending one
  assign redirect        = i_br_bus.br_sel | pend_q;
  assign redirect_target = i_br_bus.br_sel ? i_br_bus.br_target : pend_target_q;
  assign nxt_pc          = redirect ? redirect_target : pc_q + fe_pkg::PC_STEP;

  // read goes out with the address the pc is about to take
  assign o_inst_sram_ren  = i_load;
  assign o_inst_sram_addr = nxt_pc[fe_pkg::PC_WD-1:3];
  assign o_pc             = pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q   <= fe_pkg::PC_RESETVAL - fe_pkg::PC_STEP; // first load steps onto resetval
      pend_q <= 1'b0;
    end else if (i_load) begin
      pc_q   <= nxt_pc;
      pend_q <= 1'b0;
    end else if (i_br_bus.br_sel) begin
      pend_q <= 1'b1;
    end
  end

  // saved target, only meaningful while pend_q is set
  always_ff @(posedge i_clk) begin
    if (!i_load && i_br_bus.br_sel) begin
      pend_target_q <= i_br_bus.br_target;
    end
  end

endmodule

// File: verilog/fe_if_stage.sv
// fetch stage that holds the fetched item and picks its half of the 64-bit sram word
`timescale 1ns/10ps

module fe_if_stage (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic [fe_pkg::PC_WD-1:0]        i_pc,
  input  logic [fe_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  output logic                           o_load,
  fetch_if.producer                      fs
);

  logic                       to_fs_valid;
  logic                       fs_valid;
  logic                       fs_allowin;
  logic [fe_pkg::INST_WD-1:0] fs_inst;

  // nothing to fetch while the core is held in reset
  assign to_fs_valid = ~i_rst;

  // empty stage or the current item moves on to decode
  assign fs_allowin = ~fs_valid | fs.allowin;

  // new pc and sram read in the same cycle
  assign o_load = to_fs_valid & fs_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_valid <= 1'b0;
    end else if (o_load) begin
      fs_valid <= 1'b1; // data arrives with the pc one cycle after the load
    end
  end

  // sram word is 64-bit aligned
  // pc[2] set means the instruction sits in the upper half
  always_comb begin
    if (i_pc[2]) begin
      fs_inst = i_inst_sram_rdata[fe_pkg::SRAM_DATA_WD-1:fe_pkg::INST_WD];
    end else begin
      fs_inst = i_inst_sram_rdata[fe_pkg::INST_WD-1:0];
    end
  end

  assign fs.valid = fs_valid;
  assign fs.inst  = fs_inst;
  assign fs.pc    = i_pc; // pc register doubles as the stage pc

endmodule

// File: verilog/fe_id_stage.sv
// decode stage that classifies instructions, resolves jal and drops wrong-path fetches
`timescale 1ns/10ps

module fe_id_stage (
  input  logic                     i_clk,
  input  logic                     i_rst,
  fetch_if.consumer                fs,
  input  logic                     i_es_allowin,
  output fe_pkg::br_bus_t          o_br_bus,
  output logic                     o_ds_valid,
  output logic [fe_pkg::INST_WD-1:0] o_ds_inst,
  output logic [fe_pkg::PC_WD-1:0]   o_ds_pc,
  output fe_pkg::op_e              o_ds_op
);

  logic                       ds_valid;
  logic                       ds_allowin;
  logic [fe_pkg::INST_WD-1:0] ds_inst;
  logic [fe_pkg::PC_WD-1:0]   ds_pc;
  fe_pkg::op_e                ds_op;

  logic [fe_pkg::PC_WD-1:0]   exp_pc;   // pc of the next on-path instruction
  logic                       fs_go;    // fetch item transfers this cycle
  logic                       on_path;
  logic                       keep;
  fe_pkg::op_e                fs_op;
  logic [fe_pkg::PC_WD-1:0]   jal_imm;
  logic [fe_pkg::PC_WD-1:0]   nxt_exp_pc;

  logic                       br_sel_q;
  logic [fe_pkg::PC_WD-1:0]   br_target_q;

  assign ds_allowin  = ~ds_valid | i_es_allowin;
  assign fs.allowin  = ds_allowin;

  assign fs_go   = fs.valid & ds_allowin;
  assign on_path = (fs.pc == exp_pc);
  assign keep    = fs_go & on_path; // anything else was fetched past a jump

  // opcode class
  always_comb begin
    case (fs.inst[6:0])
      fe_pkg::OPC_JAL:   fs_op = fe_pkg::OP_JAL;
      fe_pkg::OPC_LOAD:  fs_op = fe_pkg::OP_LOAD;
      fe_pkg::OPC_STORE: fs_op = fe_pkg::OP_STORE;
      fe_pkg::OPC_ALU,
      fe_pkg::OPC_ALUI:  fs_op = fe_pkg::OP_ALU;
      default:           fs_op = fe_pkg::OP_OTHER;
    endcase
  end

  // j-type immediate from imm[20|10:1|11|19:12]
  assign jal_imm = {{12{fs.inst[31]}}, fs.inst[19:12], fs.inst[20], fs.inst[30:21], 1'b0};

  always_comb begin
    if (fs_op == fe_pkg::OP_JAL) begin
      nxt_exp_pc = fs.pc + jal_imm;
    end else begin
      nxt_exp_pc = fs.pc + fe_pkg::PC_STEP;
    end
  end

  // control state
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
      exp_pc   <= fe_pkg::PC_RESETVAL;
      br_sel_q <= 1'b0;
    end else begin
      if (ds_allowin) begin
        ds_valid <= fs.valid & on_path; // wrong-path item leaves ds empty
      end
      if (keep) begin
        exp_pc <= nxt_exp_pc;
      end
      br_sel_q <= keep & (fs_op == fe_pkg::OP_JAL); // single-cycle pulse
    end
  end

  // payload loaded only by an on-path transfer
  always_ff @(posedge i_clk) begin
    if (keep) begin
      ds_inst     <= fs.inst;
      ds_pc       <= fs.pc;
      ds_op       <= fs_op;
      br_target_q <= nxt_exp_pc;
    end
  end

  assign o_br_bus.br_sel    = br_sel_q;
  assign o_br_bus.br_target = br_target_q;

  assign o_ds_valid = ds_valid;
  assign o_ds_inst  = ds_inst;
  assign o_ds_pc    = ds_pc;
  assign o_ds_op    = ds_op;

endmodule

// File: verilog/fe_top.sv
// fetch front end top, pc generator, fetch and decode stages around an external inst sram
`timescale 1ns/10ps

module fe_top (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_es_allowin,
  // inst sram interface
  input  logic [fe_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  output logic                           o_inst_sram_ren,
  output logic [fe_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  // to execute stage
  output logic                           o_ds_valid,
  output logic [fe_pkg::INST_WD-1:0]      o_ds_inst,
  output logic [fe_pkg::PC_WD-1:0]        o_ds_pc,
  output fe_pkg::op_e                    o_ds_op
);

  logic                     load;
  logic [fe_pkg::PC_WD-1:0] fs_pc;
  fe_pkg::br_bus_t          br_bus;

  fetch_if fs_ds ();

  fe_pc_gen u_pc_gen (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_load           (load),
    .i_br_bus         (br_bus),   // jal resolved in decode
    .o_pc             (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  fe_if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_pc              (fs_pc),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_load            (load),
    .fs                (fs_ds.producer)
  );

  fe_id_stage u_id_stage (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .fs           (fs_ds.consumer),
    .i_es_allowin (i_es_allowin),
    .o_br_bus     (br_bus),
    .o_ds_valid   (o_ds_valid),
    .o_ds_inst    (o_ds_inst),
    .o_ds_pc      (o_ds_pc),
    .o_ds_op      (o_ds_op)
  );

endmodule

// File: sim/tb_inst_mem.sv
// synchronous instruction sram model whose word contents come from a testbench lookup
`timescale 1ns/10ps

module tb_inst_mem (
  input  logic                           i_clk,
  input  logic                           i_ren,
  input  logic [fe_pkg::SRAM_ADDR_WD-1:0] i_addr,
  // contents lookup of the word stored at o_fill_addr
  output logic [fe_pkg::SRAM_ADDR_WD-1:0] o_fill_addr,
  input  logic [fe_pkg::SRAM_DATA_WD-1:0] i_fill_word,
  output logic [fe_pkg::SRAM_DATA_WD-1:0] o_rdata
);

  logic [fe_pkg::SRAM_ADDR_WD-1:0] addr_q;
  logic                            read_seen = 1'b0; // rdata undefined until the first read

  // registered address keeps rdata steady while ren is low
  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      addr_q    <= i_addr;
      read_seen <= 1'b1;
    end
  end

  assign o_fill_addr = addr_q;

  always_comb begin
    if (read_seen) begin
      o_rdata = i_fill_word;
    end else begin
      o_rdata = 'x;
    end
  end

endmodule

// File: sim/tb_fe_top.sv
// testbench for fe_top, random back-pressure against a program-walk reference model
`timescale 1ns/10ps

module tb_fe_top;

  localparam logic [31:0] SEED           = 32'h5f456960;
  localparam int          NUM_XFERS      = 2000;
  localparam int          TIMEOUT_CYCLES = 20000;

  logic                            clk = 1'b0;
  logic                            rst;
  logic                            es_allowin;
  logic [fe_pkg::SRAM_DATA_WD-1:0] sram_rdata;
  logic                            sram_ren;
  logic [fe_pkg::SRAM_ADDR_WD-1:0] sram_addr;
  logic [fe_pkg::SRAM_ADDR_WD-1:0] fill_addr;
  logic [fe_pkg::SRAM_DATA_WD-1:0] fill_data;
  logic                            ds_valid;
  logic [fe_pkg::INST_WD-1:0]      ds_inst;
  logic [fe_pkg::PC_WD-1:0]        ds_pc;
  fe_pkg::op_e                     ds_op;

  // reference model state
  logic [31:0]  exp_pc = fe_pkg::PC_RESETVAL;
  int           xfer_count = 0;
  int           jal_count = 0;
  logic         hold_q = 1'b0;   // item was stalled at the last edge
  logic [31:0]  held_pc;
  logic [31:0]  held_inst;
  fe_pkg::op_e  held_op;

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // per-instruction random word, from the full byte pc
  function automatic logic [31:0] mix(input logic [31:0] pc);
    return lcg(lcg(pc ^ SEED));
  endfunction

  // jump distance in bytes, 0 for anything but a jal
  function automatic logic [31:0] jump_at(input logic [31:0] pc);
    logic [31:0] r;
    r = mix(pc);
    if (r[30:28] == 3'd0) begin
      return ({28'd0, r[25:22]} + 32'd1) << 2; // 4 to 64 bytes ahead
    end
    return 32'd0;
  endfunction

  function automatic logic [31:0] inst_at(input logic [31:0] pc);
    logic [31:0] r;
    logic [31:0] bits;
    logic [31:0] off;
    logic [6:0]  opc;
    r    = mix(pc);
    bits = lcg(r);
    off  = jump_at(pc);
    if (off != 32'd0) begin
      return {off[20], off[10:1], off[11], off[19:12], bits[11:7], fe_pkg::OPC_JAL};
    end
    case (r[27:26])
      2'd0:    opc = fe_pkg::OPC_LOAD;
      2'd1:    opc = fe_pkg::OPC_STORE;
      2'd2:    opc = fe_pkg::OPC_ALU;
      default: opc = fe_pkg::OPC_ALUI;
    endcase
    return {bits[31:7], opc};
  endfunction

  // class the generator chose, independent of any opcode decode
  function automatic fe_pkg::op_e op_at(input logic [31:0] pc);
    logic [31:0] r;
    r = mix(pc);
    if (jump_at(pc) != 32'd0) begin
      return fe_pkg::OP_JAL;
    end
    case (r[27:26])
      2'd0:    return fe_pkg::OP_LOAD;
      2'd1:    return fe_pkg::OP_STORE;
      default: return fe_pkg::OP_ALU;
    endcase
  endfunction

  function automatic logic [63:0] fill_word(input logic [28:0] addr);
    return {inst_at({addr, 3'b100}), inst_at({addr, 3'b000})};
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  assign fill_data = fill_word(fill_addr);

  fe_top u_fe_top (
    .i_clk             (clk),
    .i_rst             (rst),
    .i_es_allowin      (es_allowin),
    .i_inst_sram_rdata (sram_rdata),
    .o_inst_sram_ren   (sram_ren),
    .o_inst_sram_addr  (sram_addr),
    .o_ds_valid        (ds_valid),
    .o_ds_inst         (ds_inst),
    .o_ds_pc           (ds_pc),
    .o_ds_op           (ds_op)
  );

  tb_inst_mem u_inst_mem (
    .i_clk       (clk),
    .i_ren       (sram_ren),
    .i_addr      (sram_addr),
    .o_fill_addr (fill_addr),
    .i_fill_word (fill_data),
    .o_rdata     (sram_rdata)
  );

  // execute-side back-pressure, roughly 70 % ready
  initial begin
    logic [31:0] rnd;
    rnd        = SEED;
    es_allowin = 1'b0;
    forever begin
      @(negedge clk);
      rnd        = lcg(rnd);
      es_allowin = (rnd[31:24] < 8'd179);
    end
  end

  // monitor, edge values are the ones before the flops update
  always @(posedge clk) begin
    logic [31:0] step;
    if (!rst) begin
      if (hold_q) begin
        check_eq(64'(ds_valid), 64'd1, "o_ds_valid dropped under back-pressure");
        check_eq(64'(ds_pc), 64'(held_pc), "o_ds_pc changed under back-pressure");
        check_eq(64'(ds_inst), 64'(held_inst), "o_ds_inst changed under back-pressure");
        check_eq(64'(ds_op), 64'(held_op), "o_ds_op changed under back-pressure");
      end
      if (ds_valid && es_allowin) begin
        check_eq(64'(ds_pc), 64'(exp_pc), "o_ds_pc");
        check_eq(64'(ds_inst), 64'(inst_at(exp_pc)), "o_ds_inst");
        check_eq(64'(ds_op), 64'(op_at(exp_pc)), "o_ds_op");
        step = jump_at(exp_pc);
        if (step != 32'd0) begin
          jal_count = jal_count + 1;
          exp_pc    = exp_pc + step; // jal target
        end else begin
          exp_pc    = exp_pc + 32'd4;
        end
        xfer_count = xfer_count + 1;
      end
      hold_q    = ds_valid && !es_allowin;
      held_pc   = ds_pc;
      held_inst = ds_inst;
      held_op   = ds_op;
    end
  end

  initial begin
    int cycles;
    rst = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_eq(64'(ds_valid), 64'd0, "o_ds_valid during reset");
      check_eq(64'(sram_ren), 64'd0, "o_inst_sram_ren during reset");
    end
    rst    = 1'b0;
    cycles = 0;
    while (xfer_count < NUM_XFERS && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (xfer_count < NUM_XFERS) begin
      $display("timeout: only %0d of %0d transfers seen after %0d cycles",
               xfer_count, NUM_XFERS, cycles);
      $display("=== FAIL ===");
      $fatal(1, "decode stream stopped");
    end else begin
      $display("%0d transfers checked, %0d of them jal", xfer_count, jal_count);
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: all.f
verilog/fe_pkg.sv
verilog/fetch_if.sv
verilog/fe_pc_gen.sv
verilog/fe_if_stage.sv
verilog/fe_id_stage.sv
verilog/fe_top.sv
sim/tb_inst_mem.sv
sim/tb_fe_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_fe_top -f all.f -o tb_fe_top

# a failing run must not stop the script before its output is searched
sim_out=$(./obj_dir/tb_fe_top || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "=== PASS ==="; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
